/* compile.f */
verilog/fetch_pkg.sv
verilog/fetch_control.sv
verilog/program_counter.sv
verilog/instruction_memory.sv
verilog/if_id_pc_reg.sv
verilog/fetch_stage.sv
verification/fetch_stage_assertions.sv
verification/fetch_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module fetch_stage_tb \
   -f compile.f \
   -o fetch_stage_sim

./obj_dir/fetch_stage_sim > sim.log 2>&1
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
   exit 0
else
   exit 1
fi

/* verification/fetch_stage_assertions.sv */
`timescale 1ns/1ps

module fetch_stage_assertions
   import fetch_pkg::*;
   (
   input logic         i_clk,
   input logic         i_rst,
   input logic         i_start,
   input logic         i_halt,
   input fetch_state_t i_state,     // Control FSM state
   input logic         i_pc_clear,
   input logic         i_if_id_we,
   input logic         i_mem_we
   );

   logic run_q;   // Run flag rebuilt from the start and halt strobes

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         run_q <= 1'b0;
      end else if (i_halt) begin
         run_q <= 1'b0;               // Halt wins over start
      end else if (i_start) begin
         run_q <= 1'b1;
      end
   end

   // FSM follows the start and halt strobes
   a_state_tracks_strobes : assert property (
      @(posedge i_clk) disable iff (i_rst)
      (i_state == ST_RUN) == run_q
   ) else $error("Control state does not follow the start and halt strobes");

   // RAM writes only from the load port while loading
   a_mem_we_load_only : assert property (
      @(posedge i_clk) disable iff (i_rst)
      !(i_mem_we && run_q)
   ) else $error("RAM write enable high while running");

   // IF/ID never moves while loading
   a_if_id_we_run_only : assert property (
      @(posedge i_clk) disable iff (i_rst)
      !(i_if_id_we && !run_q)
   ) else $error("IF/ID write enable high while loading");

   // PC clear only in the start cycle
   a_pc_clear_on_start : assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_pc_clear |-> (i_start && !run_q)
   ) else $error("PC clear outside a start cycle");

endmodule

/* verification/fetch_stage_tb.sv */
`timescale 1ns/1ps

module fetch_stage_tb
   import fetch_pkg::*;
   ;

   localparam int DEPTH_BITS      = 6;
   localparam int WORDS           = 2**DEPTH_BITS;
   localparam int CLK_PERIOD      = 4;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 400;   // Longest test stays well below this
   localparam int MARGIN_CYCLES   = 200;   // Reset and wind-down

   logic                  i_clk = 1'b0;
   logic                  i_rst;
   logic                  i_start;
   logic                  i_halt;
   logic                  i_load_we;
   logic [DEPTH_BITS-1:0] i_load_addr;
   instr_t                i_load_data;
   logic                  i_stall;
   logic                  i_flush;
   pc_t                   i_redirect_pc;
   instr_t                o_if_id_instr;
   pc_t                   o_if_id_pc_plus4;
   pc_t                   o_pc;
   logic                  o_running;

   // Reference model state
   instr_t m_ram [WORDS];
   pc_t    m_pc;
   logic   m_run;
   instr_t m_instr;
   pc_t    m_pc4;
   logic   model_valid = 1'b0;
   int     checks = 0;
   int     errors = 0;

   bind fetch_control fetch_stage_assertions u_assertions (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_halt     (i_halt),
      .i_state    (state),
      .i_pc_clear (o_pc_clear),
      .i_if_id_we (o_if_id_we),
      .i_mem_we   (o_mem_we)
   );

   fetch_stage #(
      .NB_DEPTH (DEPTH_BITS)
   ) uut (
      .i_clk            (i_clk),
      .i_rst            (i_rst),
      .i_start          (i_start),
      .i_halt           (i_halt),
      .i_load_we        (i_load_we),
      .i_load_addr      (i_load_addr),
      .i_load_data      (i_load_data),
      .i_stall          (i_stall),
      .i_flush          (i_flush),
      .i_redirect_pc    (i_redirect_pc),
      .o_if_id_instr    (o_if_id_instr),
      .o_if_id_pc_plus4 (o_if_id_pc_plus4),
      .o_pc             (o_pc),
      .o_running        (o_running)
   );

   always #(CLK_PERIOD/2) i_clk = ~i_clk;

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         m_ram[i] = NOP_INSTR;  // RAM starts cleared
      end
   end

   // One clock edge of the fetch stage as the rules describe it
   function automatic void model_step();
      logic                  clr;
      logic                  adv;
      logic                  fl;
      logic                  we;
      logic [DEPTH_BITS-1:0] addr;
      if (i_rst) begin
         m_run   = 1'b0;
         m_pc    = '0;
         m_instr = NOP_INSTR;
         m_pc4   = '0;
         return;
      end
      clr  = !m_run && i_start;
      adv  = m_run && (!i_stall || i_flush);      // Flush beats stall
      fl   = m_run && i_flush;
      we   = !m_run && i_load_we;                 // Loads only in ST_LOAD
      addr = m_run ? m_pc[DEPTH_BITS+1:2] : i_load_addr;
      if (we) begin
         m_ram[addr] = i_load_data;               // IF/ID holds on a write
      end else if (adv && fl) begin
         m_instr = NOP_INSTR;
         m_pc4   = '0;
      end else if (adv) begin
         m_instr = m_ram[addr];
         m_pc4   = m_pc + PC_STEP;
      end
      if (clr) begin
         m_pc = '0;
      end else if (adv) begin
         m_pc = fl ? i_redirect_pc : m_pc + PC_STEP;
      end
      if (!m_run) begin
         m_run = i_start && !i_halt;              // Halt wins over start
      end else begin
         m_run = !i_halt;
      end
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   always @(posedge i_clk) begin
      model_step();
      model_valid = 1'b1;
   end

   // Outputs settle long before the falling edge
   always @(negedge i_clk) begin
      if (model_valid) begin
         check_value(o_if_id_instr, m_instr, "IF/ID instruction");
         check_value(o_if_id_pc_plus4, m_pc4, "IF/ID PC+4");
         check_value(o_pc, m_pc, "PC");
         check_value({31'b0, o_running}, {31'b0, m_run}, "running flag");
      end
   end

   // Strobes drop after one cycle while stall stays a level
   task automatic tick();
      @(posedge i_clk);
      #1;
      i_start   = 1'b0;
      i_halt    = 1'b0;
      i_load_we = 1'b0;
      i_flush   = 1'b0;
   endtask

   task automatic load_program();
      for (int a = 0; a < WORDS; a++) begin
         i_load_we   = 1'b1;
         i_load_addr = a[DEPTH_BITS-1:0];
         i_load_data = $urandom();
         tick();
      end
   endtask

   task automatic start_and_run(input int cycles);
      i_start = 1'b1;
      tick();
      repeat (cycles) tick();
   endtask

   task automatic run_random(input int cycles, input int flush_odds);
      int unsigned r;
      repeat (cycles) begin
         i_stall = ($urandom_range(3, 0) == 0);
         if (flush_odds > 0 && $urandom_range(flush_odds - 1, 0) == 0) begin
            r             = $urandom_range(WORDS - 1, 0);
            i_flush       = 1'b1;
            i_redirect_pc = r << 2;  // Word-aligned target
         end
         tick();
      end
      i_stall = 1'b0;
   endtask

   // Watchdog sized from the test lengths
   initial begin
      #((NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Timeout: simulation did not finish within the expected time");
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      int unsigned r;
      void'($urandom(32'hba3b3482));
      i_rst         = 1'b1;
      i_start       = 1'b0;
      i_halt        = 1'b0;
      i_load_we     = 1'b0;
      i_load_addr   = '0;
      i_load_data   = '0;
      i_stall       = 1'b0;
      i_flush       = 1'b0;
      i_redirect_pc = '0;
      repeat (16) tick();
      i_rst = 1'b0;

      // Stall and flush leave the reset defaults alone while loading
      i_stall       = 1'b1;
      i_flush       = 1'b1;
      i_redirect_pc = 32'h40;
      tick();
      i_stall = 1'b0;
      repeat (4) tick();

      // Load then straight run past the last word
      load_program();
      start_and_run(WORDS + 8);

      run_random(150, 0);  // Random stalls
      run_random(150, 6);  // Stalls mixed with flushes

      // Flush in a stalled cycle
      i_stall       = 1'b1;
      i_flush       = 1'b1;
      i_redirect_pc = 32'h20;
      tick();
      i_stall = 1'b0;
      repeat (4) tick();

      // Loads during a run are dropped
      repeat (20) begin
         r           = $urandom_range(WORDS - 1, 0);
         i_load_we   = 1'b1;
         i_load_addr = r[DEPTH_BITS-1:0];
         i_load_data = $urandom();
         tick();
      end
      repeat (WORDS) tick();

      // Halt freezes the outputs and a start paired with halt stays loading
      i_halt = 1'b1;
      tick();
      repeat (10) tick();
      i_start = 1'b1;
      i_halt  = 1'b1;
      tick();
      repeat (3) tick();

      // New program from address 0
      load_program();
      start_and_run(WORDS + 8);
      repeat (2) tick();

      $display("Checks run: %0d, mismatches: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* verilog/fetch_control.sv */
`timescale 1ns/1ps

module fetch_control
   import fetch_pkg::*;
   (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_start,     // Strobe, leave load and start fetching
   input  logic i_halt,      // Strobe, back to load
   input  logic i_stall,     // Level hold from the hazard unit
   input  logic i_flush,     // Strobe, branch or jump redirect
   input  logic i_load_we,   // Strobe, program word write
   output logic o_pc_clear,
   output logic o_pc_write,
   output logic o_if_id_we,
   output logic o_ctr_flush,
   output logic o_mem_we,
   output logic o_running
   );

   fetch_state_t state;
   fetch_state_t state_next;
   logic         loading;
   logic         running;
   logic         advance;   // PC and IF/ID move this cycle

   assign loading = (state == ST_LOAD);
   assign running = (state == ST_RUN);

   // Next state, halt beats start when both arrive together
   always_comb begin
      state_next = state;
      case (state)
         ST_LOAD: begin
            if (i_start && !i_halt) begin
               state_next = ST_RUN;
            end
         end
         ST_RUN: begin
            if (i_halt) begin
               state_next = ST_LOAD;
            end
         end
         default: state_next = ST_LOAD;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= ST_LOAD;
      end else begin
         state <= state_next;
      end
   end

   // Flush overrides stall, so a running flush always writes IF/ID
   assign advance = running && (!i_stall || i_flush);

   assign o_pc_clear  = loading && i_start;    // PC back to word 0 on start
   assign o_pc_write  = advance;
   assign o_if_id_we  = advance;               // Same enable keeps PC and IF/ID in step
   assign o_ctr_flush = running && i_flush;    // Flush ignored while loading
   assign o_mem_we    = loading && i_load_we;  // Loads during a run are dropped
   assign o_running   = running;

   // Note the halt edge itself still advances when not stalled,
   // the freeze starts once the state is back in ST_LOAD

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

   // Instruction word as fetched from the RAM
   typedef logic [31:0] instr_t;

   // Byte address held in the PC
   typedef logic [31:0] pc_t;

   // sll $0,$0,0 encodes as all zeros
   localparam instr_t NOP_INSTR = 32'h0000_0000;

   // One word per fetch
   localparam pc_t PC_STEP = 32'd4;

   // Fetch control states
   typedef enum logic {
      ST_LOAD = 1'b0,  // Program load through the write port
      ST_RUN  = 1'b1   // Pipeline fetching
   } fetch_state_t;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
   import fetch_pkg::*;
   #(
   parameter int NB_DEPTH = 10  // 1024 words by default
   )
   (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_start,
   input  logic                i_halt,
   input  logic                i_load_we,
   input  logic [NB_DEPTH-1:0] i_load_addr,
   input  instr_t              i_load_data,
   input  logic                i_stall,
   input  logic                i_flush,
   input  pc_t                 i_redirect_pc,
   output instr_t              o_if_id_instr,
   output pc_t                 o_if_id_pc_plus4,
   output pc_t                 o_pc,
   output logic                o_running
   );

   logic                pc_clear;
   logic                pc_write;
   logic                if_id_we;
   logic                ctr_flush;
   logic                mem_we;
   logic                running;
   pc_t                 pc;
   logic [NB_DEPTH-1:0] mem_addr;

   fetch_control u_control (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_start     (i_start),
      .i_halt      (i_halt),
      .i_stall     (i_stall),
      .i_flush     (i_flush),
      .i_load_we   (i_load_we),
      .o_pc_clear  (pc_clear),
      .o_pc_write  (pc_write),
      .o_if_id_we  (if_id_we),
      .o_ctr_flush (ctr_flush),
      .o_mem_we    (mem_we),
      .o_running   (running)
   );

   program_counter u_pc (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_pc_clear    (pc_clear),
      .i_pc_write    (pc_write),
      .i_flush       (ctr_flush),
      .i_redirect_pc (i_redirect_pc),
      .o_pc          (pc)
   );

   // Load port owns the address in ST_LOAD, PC word index in ST_RUN
   assign mem_addr = running ? pc[NB_DEPTH+1:2] : i_load_addr;

   instruction_memory #(
      .NB_DEPTH (NB_DEPTH)
   ) u_imem (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_we        (mem_we),
      .i_if_id_we  (if_id_we),
      .i_ctr_flush (ctr_flush),
      .i_addr      (mem_addr),
      .i_data      (i_load_data),
      .o_data      (o_if_id_instr)
   );

   if_id_pc_reg u_if_id_pc (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_if_id_we  (if_id_we),
      .i_ctr_flush (ctr_flush),
      .i_pc        (pc),
      .o_pc_plus4  (o_if_id_pc_plus4)
   );

   assign o_pc      = pc;
   assign o_running = running;

endmodule

/* verilog/if_id_pc_reg.sv */
`timescale 1ns/1ps

module if_id_pc_reg
   import fetch_pkg::*;
   (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_if_id_we,   // Shared with the instruction half
   input  logic i_ctr_flush,  // Shared with the instruction half
   input  pc_t  i_pc,         // PC of the word being fetched
   output pc_t  o_pc_plus4    // PC+4 paired with the IF/ID instruction
   );

   pc_t pc_plus4;
   pc_t pc_plus4_q;

   assign pc_plus4 = i_pc + PC_STEP;

   // Same case split as the RAM output register
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_plus4_q <= '0;
      end else begin
         case ({i_ctr_flush, i_if_id_we})
            2'b01:   pc_plus4_q <= pc_plus4;
            2'b11:   pc_plus4_q <= '0;          // Bubble carries no PC
            default: pc_plus4_q <= pc_plus4_q;
         endcase
      end
   end

   assign o_pc_plus4 = pc_plus4_q;

endmodule

/* verilog/instruction_memory.sv */
`timescale 1ns/1ps

module instruction_memory
   import fetch_pkg::*;
   #(
   parameter int NB_DEPTH = 10  // Word address bits
   )
   (
   input  logic                i_clk,
   input  logic                i_rst,        // Clears the output register only
   input  logic                i_we,         // Program load write
   input  logic                i_if_id_we,   // IF/ID write enable
   input  logic                i_ctr_flush,  // Replace fetched word by NOP
   input  logic [NB_DEPTH-1:0] i_addr,       // Word address
   input  instr_t              i_data,
   output instr_t              o_data        // Instruction half of IF/ID
   );

   localparam int RAM_DEPTH = 2**NB_DEPTH;

   instr_t ram [RAM_DEPTH];
   instr_t ram_data;   // Registered read, doubles as IF/ID instruction

   // Contents start cleared, no reset on the array
   initial begin
      for (int i = 0; i < RAM_DEPTH; i++) begin
         ram[i] = NOP_INSTR;
      end
   end

   // Write port
   always_ff @(posedge i_clk) begin
      if (i_we) begin
         ram[i_addr] <= i_data;
      end
   end

   // Read port with IF/ID behaviour
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ram_data <= NOP_INSTR;
      end else if (i_we) begin
         ram_data <= ram_data;            // Write wins, read side holds
      end else begin
         case ({i_ctr_flush, i_if_id_we})
            2'b01:   ram_data <= ram[i_addr];  // Normal fetch
            2'b11:   ram_data <= NOP_INSTR;    // Bubble on redirect
            default: ram_data <= ram_data;     // Stall or idle
         endcase
      end
   end

   assign o_data = ram_data;

endmodule

/* verilog/program_counter.sv */
`timescale 1ns/1ps

module program_counter
   import fetch_pkg::*;
   (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_pc_clear,     // Start of a run
   input  logic i_pc_write,     // Advance or redirect
   input  logic i_flush,        // Take the redirect target
   input  pc_t  i_redirect_pc,  // Word-aligned target from branch resolution
   output pc_t  o_pc
   );

   pc_t pc;
   pc_t pc_next;
   pc_t pc_step;

   assign pc_step = pc + PC_STEP;  // Sequential successor

   // Clear first, then redirect, then step, else hold
   always_comb begin
      pc_next = pc;
      if (i_pc_clear) begin
         pc_next = '0;
      end else if (i_pc_write) begin
         if (i_flush) begin
            pc_next = i_redirect_pc;
         end else begin
            pc_next = pc_step;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc <= '0;
      end else begin
         pc <= pc_next;
      end
   end

   assign o_pc = pc;

endmodule
